/* logic/tcdm_pkg.sv */
// TCDM subsystem package
// Default widths and sizes of the single-initiator word-interleaved TCDM,
// plus the vector types that carry those widths outside the design
package tcdm_pkg;

  // Byte address width seen by the initiator
  localparam int unsigned DEFAULT_AW = 32;

  // Data word width; one byte enable per byte of the word
  localparam int unsigned DEFAULT_DW = 32;

  // Width of the request user tag, echoed back through r_user
  localparam int unsigned DEFAULT_UW = 8;

  // Number of interleaved banks and words held by each one
  localparam int unsigned DEFAULT_N_BANKS    = 4;
  localparam int unsigned DEFAULT_BANK_DEPTH = 64;

  // Byte address of a request
  typedef logic [DEFAULT_AW-1:0] tcdm_addr_t;

  // One data word, for write data and read data alike
  typedef logic [DEFAULT_DW-1:0] tcdm_data_t;

  // Byte enables, bit n covers bits 8n+7 down to 8n of the word
  typedef logic [DEFAULT_DW/8-1:0] tcdm_be_t;

  // User tag carried by a request
  typedef logic [DEFAULT_UW-1:0] tcdm_user_t;

endpackage

/* logic/tcdm_if.sv */
// TCDM request/response interface
// Request side is driven by the initiator, response side by the target.
// A request is accepted when req and gnt are both high, and its response
// shows up with r_valid one cycle later
`timescale 1ns/1ps

interface tcdm_if import tcdm_pkg::*; #(
  parameter int unsigned AW = DEFAULT_AW,  // Byte address width
  parameter int unsigned DW = DEFAULT_DW,  // Data width
  parameter int unsigned UW = DEFAULT_UW   // User tag width
) ();

  // Request channel
  logic          req;     // Request strobe
  logic [AW-1:0] add;     // Byte address, word aligned
  logic          wen;     // High for a read, low for a write
  logic [DW/8-1:0] be;    // Byte enables of a write
  logic [DW-1:0] data;    // Write data
  logic [UW-1:0] user;    // Request tag

  // Response channel
  logic          gnt;     // Grant, the request is taken this cycle
  logic          r_valid; // Response strobe, one cycle after the grant
  logic [DW-1:0] r_data;  // Read data, zero for writes and errors
  logic          r_opc;   // High when the access failed
  logic [UW-1:0] r_user;  // Response tag

  // The initiator owns the request, the target answers it
  modport initiator (
    output req, add, wen, be, data, user,
    input  gnt, r_valid, r_data, r_opc, r_user
  );

  modport target (
    input  req, add, wen, be, data, user,
    output gnt, r_valid, r_data, r_opc, r_user
  );

endinterface

/* logic/tcdm_r_user_filter.sv */
// TCDM response-user filter
// Passes request and response through untouched, except that the user tag
// is kept locally. Downstream sees a zero user, and the initiator gets the
// registered tag of the last accepted request back as r_user
`timescale 1ns/1ps

module tcdm_r_user_filter import tcdm_pkg::*; #(
  parameter int unsigned UW = DEFAULT_UW  // User tag width
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear,   // Zeroes the stored tag, wins over a load
  input  logic      enable,  // Allows accepted requests to load their tag
  tcdm_if.target    up,      // Towards the initiator
  tcdm_if.initiator dn       // Towards the bank decoder
);

  logic [UW-1:0] user_q;  // Tag of the last accepted request with enable high
  logic          accept;  // Request handshake completes this cycle

  assign accept = up.req & dn.gnt;

  // Request side goes straight through
  assign dn.req  = up.req;
  assign dn.add  = up.add;
  assign dn.wen  = up.wen;
  assign dn.be   = up.be;
  assign dn.data = up.data;
  assign dn.user = '0;           // Tag stays here and never reaches the banks

  // Response side is returned as is, apart from the tag
  assign up.gnt     = dn.gnt;
  assign up.r_valid = dn.r_valid;
  assign up.r_data  = dn.r_data;
  assign up.r_opc   = dn.r_opc;
  assign up.r_user  = user_q;

  // Tag register, loaded at the accepting edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      user_q <= '0;
    end else if (clear) begin
      user_q <= '0;                // Clear takes priority over a load
    end else if (enable && accept) begin
      user_q <= up.user;
    end
  end

endmodule

/* logic/tcdm_bank_decode.sv */
// TCDM bank decoder
// Splits the byte address into a bank index and a row, with consecutive
// words in consecutive banks. Out-of-range addresses reach no bank and come
// back with r_opc set. The response is assembled one cycle after the grant
`timescale 1ns/1ps

module tcdm_bank_decode import tcdm_pkg::*; #(
  parameter  int unsigned AW         = DEFAULT_AW,
  parameter  int unsigned DW         = DEFAULT_DW,
  parameter  int unsigned UW         = DEFAULT_UW,
  parameter  int unsigned N_BANKS    = DEFAULT_N_BANKS,
  parameter  int unsigned BANK_DEPTH = DEFAULT_BANK_DEPTH,
  localparam int unsigned BW         = DW / 8,
  localparam int unsigned ROW_W      = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  tcdm_if.target             up,                    // Filtered request stream
  output logic [N_BANKS-1:0] bank_req,              // One request line per bank
  output logic [N_BANKS-1:0] bank_we,               // Write strobe per bank
  output logic [ROW_W-1:0]   bank_row   [N_BANKS],  // Word row inside the bank
  output logic [BW-1:0]      bank_be    [N_BANKS],
  output logic [DW-1:0]      bank_wdata [N_BANKS],
  input  logic [DW-1:0]      bank_rdata [N_BANKS]   // Registered read data
);

  localparam int unsigned OFFS    = $clog2(BW);          // Byte offset bits
  localparam int unsigned WIDX_W  = AW - OFFS;           // Word index width
  localparam int unsigned BANK_W  = (N_BANKS > 1) ? $clog2(N_BANKS) : 1;
  localparam int unsigned N_WORDS = N_BANKS * BANK_DEPTH;

  typedef logic [BANK_W-1:0] bank_idx_t;
  typedef logic [ROW_W-1:0]  row_t;

  logic [WIDX_W-1:0] word_idx;   // Byte address with the offset dropped
  bank_idx_t         bank_idx;   // Bank addressed by the current request
  row_t              row;
  logic              oor;        // Word index beyond the last bank row
  logic              accept;

  // Response state, one entry for the access in flight
  logic      r_valid_q;
  logic      rd_q;               // The accepted access was a read
  logic      oor_q;
  bank_idx_t bank_q;

  assign word_idx = up.add[AW-1:OFFS];
  assign bank_idx = bank_idx_t'(word_idx % N_BANKS);  // Low-order interleaving
  assign row      = row_t'(word_idx / N_BANKS);
  assign oor      = (word_idx >= N_WORDS);

  // Banks are never busy, so every request is granted at once
  assign up.gnt = up.req;
  assign accept = up.req & up.gnt;

  // Only the addressed bank sees req, the rest of the request is shared
  always_comb begin
    for (int unsigned i = 0; i < N_BANKS; i++) begin
      bank_req[i]   = up.req && !oor && (bank_idx == bank_idx_t'(i));
      bank_we[i]    = !up.wen;     // wen is high for reads
      bank_row[i]   = row;
      bank_be[i]    = up.be;
      bank_wdata[i] = up.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
      rd_q      <= 1'b0;
      oor_q     <= 1'b0;
      bank_q    <= '0;
    end else begin
      r_valid_q <= accept;         // Exactly one response per accepted request
      if (accept) begin
        rd_q   <= up.wen;
        oor_q  <= oor;
        bank_q <= bank_idx;        // Selects the read mux in the next cycle
      end
    end
  end

  // Response, read data only for in-range reads
  assign up.r_valid = r_valid_q;
  assign up.r_opc   = r_valid_q & oor_q;
  assign up.r_data  = (r_valid_q && rd_q && !oor_q) ? bank_rdata[bank_q] : '0;
  assign up.r_user  = {UW{1'b0}};  // The filter supplies the real tag

endmodule

/* logic/tcdm_sram_bank.sv */
// Single-port SRAM bank
// Byte-masked writes, and read data registered one cycle after the request.
// The word array has no reset
`timescale 1ns/1ps

module tcdm_sram_bank import tcdm_pkg::*; #(
  parameter  int unsigned DW         = DEFAULT_DW,          // Word width
  parameter  int unsigned BANK_DEPTH = DEFAULT_BANK_DEPTH,  // Words in the bank
  localparam int unsigned BW         = DW / 8,
  localparam int unsigned ROW_W      = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1
) (
  input  logic             clk_i,
  input  logic             req,    // Access strobe from the decoder
  input  logic             we,     // High for a write
  input  logic [ROW_W-1:0] row,    // Word within this bank
  input  logic [BW-1:0]    be,     // Byte enables of a write
  input  logic [DW-1:0]    wdata,
  output logic [DW-1:0]    rdata   // Holds the last word read
);

  logic [DW-1:0] mem [BANK_DEPTH];

  // Write port, each enabled byte lane updates on its own
  always_ff @(posedge clk_i) begin
    if (req && we) begin
      for (int unsigned b = 0; b < BW; b++) begin
        if (be[b]) begin
          mem[row][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // Read port
  always_ff @(posedge clk_i) begin
    if (req && !we) begin
      rdata <= mem[row];           // Stays put until the next read
    end
  end

endmodule

/* logic/tcdm_subsystem.sv */
// TCDM subsystem top level
// One initiator on plain ports, the response-user filter, the bank decoder
// and an array of interleaved SRAM banks. Every request is granted at once
// and answered one cycle later
`timescale 1ns/1ps

module tcdm_subsystem import tcdm_pkg::*; #(
  parameter int unsigned AW         = DEFAULT_AW,
  parameter int unsigned DW         = DEFAULT_DW,
  parameter int unsigned UW         = DEFAULT_UW,
  parameter int unsigned N_BANKS    = DEFAULT_N_BANKS,
  parameter int unsigned BANK_DEPTH = DEFAULT_BANK_DEPTH
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            clear,    // Zeroes the returned user tag
  input  logic            enable,   // Lets requests load their user tag
  input  logic            req,
  input  logic [AW-1:0]   add,
  input  logic            wen,      // High for a read
  input  logic [DW/8-1:0] be,
  input  logic [DW-1:0]   data,
  input  logic [UW-1:0]   user,
  output logic            gnt,
  output logic            r_valid,
  output logic [DW-1:0]   r_data,
  output logic            r_opc,    // Out-of-range access
  output logic [UW-1:0]   r_user
);

  localparam int unsigned BW    = DW / 8;
  localparam int unsigned ROW_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

  // Initiator side and decoder side of the filter
  tcdm_if #(.AW(AW), .DW(DW), .UW(UW)) up_if ();
  tcdm_if #(.AW(AW), .DW(DW), .UW(UW)) dn_if ();

  // Per-bank request and read data lines
  logic [N_BANKS-1:0] bank_req;
  logic [N_BANKS-1:0] bank_we;
  logic [ROW_W-1:0]   bank_row   [N_BANKS];
  logic [BW-1:0]      bank_be    [N_BANKS];
  logic [DW-1:0]      bank_wdata [N_BANKS];
  logic [DW-1:0]      bank_rdata [N_BANKS];

  assign up_if.req  = req;
  assign up_if.add  = add;
  assign up_if.wen  = wen;
  assign up_if.be   = be;
  assign up_if.data = data;
  assign up_if.user = user;

  assign gnt     = up_if.gnt;
  assign r_valid = up_if.r_valid;
  assign r_data  = up_if.r_data;
  assign r_opc   = up_if.r_opc;
  assign r_user  = up_if.r_user;

  tcdm_r_user_filter #(.UW(UW)) i_filter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clear  (clear),
    .enable (enable),
    .up     (up_if.target),
    .dn     (dn_if.initiator)
  );

  tcdm_bank_decode #(
    .AW(AW), .DW(DW), .UW(UW), .N_BANKS(N_BANKS), .BANK_DEPTH(BANK_DEPTH)
  ) i_decode (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .up         (dn_if.target),
    .bank_req   (bank_req),
    .bank_we    (bank_we),
    .bank_row   (bank_row),
    .bank_be    (bank_be),
    .bank_wdata (bank_wdata),
    .bank_rdata (bank_rdata)
  );

  // Word n lives in bank n mod N_BANKS
  for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
    tcdm_sram_bank #(.DW(DW), .BANK_DEPTH(BANK_DEPTH)) i_bank (
      .clk_i (clk_i),
      .req   (bank_req[b]),
      .we    (bank_we[b]),
      .row   (bank_row[b]),
      .be    (bank_be[b]),
      .wdata (bank_wdata[b]),
      .rdata (bank_rdata[b])
    );
  end

endmodule

/* testbench/tcdm_subsystem_sva.sv */
// Response-user filter assertions
// Tag handling and one-cycle response timing, bound into the filter
`timescale 1ns/1ps

module tcdm_subsystem_sva import tcdm_pkg::*; #(
  parameter int unsigned UW = DEFAULT_UW
) (
  input logic          clk_i,
  input logic          rst_ni,
  input logic          clear,
  input logic          enable,
  input logic          req,
  input logic          gnt,
  input logic          r_valid,
  input logic [UW-1:0] user,     // Upstream request tag
  input logic [UW-1:0] r_user,   // Tag returned to the initiator
  input logic [UW-1:0] dn_user   // Tag seen by the decoder
);

  // The tag never leaves the filter
  dn_user_zero: assert property (@(posedge clk_i) disable iff (!rst_ni) dn_user == '0)
    else $error("Downstream user tag is not zero");

  gnt_is_req: assert property (@(posedge clk_i) disable iff (!rst_ni) gnt == req)
    else $error("gnt differs from req");

  valid_next_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid == $past(req && gnt))  // One response per accepted request
    else $error("r_valid does not follow an accepted request by one cycle");

  user_loaded: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req && gnt && enable && !clear) |=> (r_user == $past(user)))
    else $error("r_user is not the tag of the previous request");

endmodule

bind tcdm_r_user_filter tcdm_subsystem_sva #(.UW(UW)) i_sva (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .clear   (clear),
  .enable  (enable),
  .req     (up.req),
  .gnt     (up.gnt),
  .r_valid (up.r_valid),
  .user    (up.user),
  .r_user  (up.r_user),
  .dn_user (dn.user)
);

/* testbench/tcdm_subsystem_tb.sv */
// TCDM subsystem testbench
// Random word traffic checked against a shadow memory and shadow user tag
// One response is compared in the cycle after each accepted request
`timescale 1ns/1ps

module tcdm_subsystem_tb import tcdm_pkg::*; ();

  localparam int unsigned N_WORDS  = DEFAULT_N_BANKS * DEFAULT_BANK_DEPTH;
  localparam int unsigned BE_OPS   = 64;  // Partial writes that are each read back
  localparam int unsigned OOR_OPS  = 16;
  localparam int unsigned USER_OPS = 24;
  // Fill, read-back and re-read take about 3 N_WORDS cycles and the rest a few each
  localparam int unsigned MAX_CYCLES = 4 * N_WORDS + 2 * BE_OPS + OOR_OPS + 3 * USER_OPS + 100;

  typedef logic [$clog2(N_WORDS)-1:0] widx_t;
  typedef struct packed {
    tcdm_data_t data;
    logic       err;
    tcdm_user_t user;
  } resp_t;

  logic clk_i  = 1'b0;
  logic rst_ni = 1'b0;
  logic clear  = 1'b0;
  logic enable = 1'b1;
  logic req    = 1'b0;
  logic wen    = 1'b1;  // wen high means read
  tcdm_addr_t add  = '0;
  tcdm_be_t   be   = '0;
  tcdm_data_t data = '0;
  tcdm_user_t user = '0;
  logic       gnt, r_valid, r_opc;
  tcdm_data_t r_data;
  tcdm_user_t r_user;

  tcdm_data_t  shadow_mem [N_WORDS];  // Reference copy of all banks
  tcdm_user_t  shadow_user = '0;      // Reference copy of the filter tag
  resp_t       pending [$];           // Responses due in the next cycle
  string       test_name = "reset";
  int unsigned errors, checks, cycles, last_errors;

  tcdm_subsystem dut0 (.*);

  always #10 clk_i = ~clk_i;

  task automatic check_data(string name, tcdm_data_t expected, tcdm_data_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_user(string name, tcdm_user_t expected, tcdm_user_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // Response owed to an access accepted now once the shadow tag is updated
  function automatic resp_t expected_resp(tcdm_addr_t a, logic rd);
    resp_t r;
    r.err  = (a >> 2) >= N_WORDS;  // Word index past the last bank row
    r.data = (rd && !r.err) ? shadow_mem[widx_t'(a >> 2)] : '0;
    r.user = shadow_user;
    return r;
  endfunction

  // Compares last cycle's response and then steps the model for this edge
  always @(posedge clk_i) begin
    resp_t want;
    if (rst_ni) begin
      check_flag({test_name, " gnt"}, req, gnt);  // Banks never push back
      if (r_valid !== (pending.size() != 0)) begin
        errors++;
        $display("r_valid was %b with %0d responses due in test %s", r_valid,
                 pending.size(), test_name);
      end
      if (pending.size() != 0) begin
        want = pending.pop_front();
        check_data({test_name, " r_data"}, want.data, r_data);
        check_flag({test_name, " r_opc"}, want.err, r_opc);
        check_user({test_name, " r_user"}, want.user, r_user);
      end
      if (clear) begin
        shadow_user = '0;                 // Clear wins over a load
      end else if (enable && req) begin
        shadow_user = user;
      end
      if (req) begin
        want = expected_resp(add, wen);
        pending.push_back(want);
        for (int b = 0; b < DEFAULT_DW / 8; b++) begin
          if (!wen && !want.err && be[b]) begin
            shadow_mem[widx_t'(add >> 2)][8*b +: 8] = data[8*b +: 8];
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout, run stopped after %0d cycles", cycles);
      $display("Errors found");
      $finish;
    end
  end

  task automatic issue(tcdm_addr_t a, logic rd, tcdm_be_t b, tcdm_data_t d, tcdm_user_t u);
    @(negedge clk_i);
    req  = 1'b1;
    add  = a;
    wen  = rd;
    be   = b;
    data = d;
    user = u;
  endtask

  task automatic idle();
    @(negedge clk_i);
    req = 1'b0;
  endtask

  // Drains the responses still in flight and reports the test
  task automatic end_test();
    idle();
    while (pending.size() != 0) begin
      @(negedge clk_i);
    end
    $display("Test %s done, %0d errors", test_name, errors - last_errors);
    last_errors = errors;
  endtask

  // Back-to-back reads of consecutive words with a random tag each
  task automatic read_seq(int unsigned first, int unsigned n);
    for (int unsigned w = first; w < first + n; w++) begin
      issue(tcdm_addr_t'(w * 4), 1'b1, '0, '0, tcdm_user_t'($urandom));
    end
  endtask

  initial begin
    tcdm_addr_t a;
    void'($urandom(32'h403c));
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_flag("reset r_valid", 1'b0, r_valid);
    check_flag("reset r_opc", 1'b0, r_opc);
    check_user("reset r_user", '0, r_user);
    end_test();

    test_name = "fill_readback";
    for (int unsigned w = 0; w < N_WORDS; w++) begin
      issue(tcdm_addr_t'(w * 4), 1'b0, '1, tcdm_data_t'($urandom), tcdm_user_t'($urandom));
    end
    read_seq(0, N_WORDS);                // Walks every bank in turn
    end_test();

    test_name = "byte_enables";
    for (int unsigned i = 0; i < BE_OPS; i++) begin
      a = tcdm_addr_t'($urandom_range(N_WORDS - 1) * 4);
      issue(a, 1'b0, tcdm_be_t'($urandom), tcdm_data_t'($urandom), '0);
      issue(a, 1'b1, '0, '0, '0);
    end
    end_test();

    test_name = "out_of_range";
    for (int unsigned i = 0; i < OOR_OPS; i++) begin
      a = tcdm_addr_t'((N_WORDS + $urandom_range(4095)) * 4);
      issue(a, i[0], '1, tcdm_data_t'($urandom), '0);  // Writes and reads alternate
    end
    issue(32'hffff_fffc, 1'b1, '0, '0, '0);
    read_seq(0, N_WORDS);                // Contents must be untouched
    end_test();

    test_name = "user_filter";
    read_seq(8, USER_OPS);               // Each response returns its own tag
    idle();
    enable = 1'b0;
    read_seq(40, USER_OPS / 2);          // Tag holds the last loaded value
    idle();
    clear = 1'b1;
    @(negedge clk_i);
    clear = 1'b0;
    check_user("user_filter after clear", '0, r_user);
    read_seq(80, 4);
    idle();
    enable = 1'b1;
    read_seq(120, 4);
    end_test();

    $display("Tests: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* sim.f */
logic/tcdm_pkg.sv
logic/tcdm_if.sv
logic/tcdm_r_user_filter.sv
logic/tcdm_bank_decode.sv
logic/tcdm_sram_bank.sv
logic/tcdm_subsystem.sv
testbench/tcdm_subsystem_sva.sv
testbench/tcdm_subsystem_tb.sv

/* Makefile */
# Verilator build and run of the TCDM subsystem testbench
VERILATOR ?= verilator
TOP       ?= tcdm_subsystem_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the run prints the pass message
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)
